//--- Makefile
TOP = ahb_sram_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- filelist.f
rtl/ahb_pkg.sv
rtl/sram_pkg.sv
rtl/ahb_transfer_decode.sv
rtl/ahb_write_buffer.sv
rtl/sram_access_ctrl.sv
rtl/sram_array.sv
rtl/ahb_sram_top.sv
testbench/ahb_sram_tb.sv

//--- rtl/ahb_pkg.sv
/*
 * AHB-Lite bus types
 * Transfer and size codes, the dual-view address word and the
 * bundle of address-phase inputs seen by the SRAM slave
 */
package ahb_pkg;

   // Transfer type on htrans
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      BUSY   = 2'b01,  // Master stalls inside a burst
      NONSEQ = 2'b10,  // First beat or single
      SEQ    = 2'b11
   } htrans_t;

   // Transfer size on hsize, wider codes unsupported
   typedef enum logic [2:0] {
      SIZE_BYTE = 3'b000,
      SIZE_HALF = 3'b001,
      SIZE_WORD = 3'b010
   } hsize_t;

   // Byte address split at the word boundary
   typedef struct packed {
      logic [29:0] word;    // Word index
      logic [1:0]  offset;  // Byte within the word
   } ahb_addr_fields_t;

   // Same 32 bits, flat or split
   typedef union packed {
      logic [31:0]      flat;
      ahb_addr_fields_t fields;
   } ahb_addr_u;

   // Address-phase inputs from the interconnect
   typedef struct packed {
      logic      hsel;
      ahb_addr_u haddr;
      htrans_t   htrans;
      logic      hwrite;
      hsize_t    hsize;
      logic      hreadym;  // Bus-wide hready, previous transfer done
   } ahb_req_t;

endpackage

//--- rtl/ahb_sram_top.sv
/*
 * AHB-Lite to SRAM bridge
 * Decoder, one-entry write buffer, access controller and array
 */
`timescale 1ns/100ps

module ahb_sram_top #(
   parameter int addr_width = 14
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  ahb_pkg::ahb_req_t               ahb_req,
   input  logic [sram_pkg::data_width-1:0] hwdata,
   output logic [sram_pkg::data_width-1:0] hrdata,
   output logic                            hready,
   output logic                            hresp
);

   sram_pkg::access_t               access;     // Address phase request
   logic                            buf_pending;
   sram_pkg::access_t               buf_entry;
   logic [sram_pkg::data_width-1:0] buf_wdata;
   logic                            drain;
   sram_pkg::sram_port_t            sram;
   logic [sram_pkg::data_width-1:0] sram_rdata;

   ahb_transfer_decode #(
      .addr_width (addr_width)
   ) decode_i (
      .ahb_req (ahb_req),
      .access  (access)
   );

   ahb_write_buffer wbuf_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .access      (access),
      .hwdata      (hwdata),
      .drain       (drain),
      .buf_pending (buf_pending),
      .buf_entry   (buf_entry),
      .buf_wdata   (buf_wdata)
   );

   sram_access_ctrl #(
      .addr_width (addr_width)
   ) ctrl_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .access      (access),
      .buf_pending (buf_pending),
      .buf_entry   (buf_entry),
      .buf_wdata   (buf_wdata),
      .drain       (drain),
      .sram        (sram),
      .sram_rdata  (sram_rdata),
      .hrdata      (hrdata),
      .hready      (hready),
      .hresp       (hresp)
   );

   sram_array #(
      .addr_width (addr_width)
   ) array_i (
      .clk   (clk),
      .sram  (sram),
      .rdata (sram_rdata)
   );

endmodule

//--- rtl/ahb_transfer_decode.sv
/*
 * AHB transfer decoder
 * Qualifies address phases and turns them into word accesses
 * with little-endian byte enables
 */
`timescale 1ns/100ps

module ahb_transfer_decode #(
   parameter int addr_width = 14
) (
   input  ahb_pkg::ahb_req_t ahb_req,
   output sram_pkg::access_t access
);

   logic                            active;  // Address phase is ours
   logic                            seq_or_nonseq;
   logic [1:0]                      offset;
   logic [sram_pkg::lane_count-1:0] be;

   // IDLE and BUSY carry no access
   assign seq_or_nonseq = (ahb_req.htrans == ahb_pkg::NONSEQ) ||
                          (ahb_req.htrans == ahb_pkg::SEQ);

   // Sampled only when the bus is ready
   assign active = ahb_req.hsel && ahb_req.hreadym && seq_or_nonseq;

   assign offset = ahb_req.haddr.flat[1:0];  // Byte lane straight off the flat view

   // Size and offset to lane enables
   always_comb begin
      case (ahb_req.hsize)
         ahb_pkg::SIZE_BYTE: be = 4'b0001 << offset;
         ahb_pkg::SIZE_HALF: be = offset[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
         default:            be = 4'b1111;  // Word, and anything wider
      endcase
   end

   always_comb begin
      access       = '0;
      access.valid = active;
      access.write = ahb_req.hwrite;
      // Word index from the split view, trimmed to the array depth
      access.addr[addr_width-1:0] = ahb_req.haddr.fields.word[addr_width-1:0];
      access.be    = be;
   end

endmodule

//--- rtl/ahb_write_buffer.sv
/*
 * One-entry AHB write buffer
 * Pairs a write address phase with the hwdata of the next cycle
 * and holds the word until the controller drains it
 */
`timescale 1ns/100ps

module ahb_write_buffer (
   input  logic                              clk,
   input  logic                              rst_n,
   input  sram_pkg::access_t                 access,
   input  logic [sram_pkg::data_width-1:0]   hwdata,
   input  logic                              drain,
   output logic                              buf_pending,
   output sram_pkg::access_t                 buf_entry,
   output logic [sram_pkg::data_width-1:0]   buf_wdata
);

   logic                            stage_vld_q;   // Write in its data phase
   sram_pkg::access_t               stage_q;
   logic                            entry_vld_q;   // Held word waiting for a free slot
   sram_pkg::access_t               entry_q;
   logic [sram_pkg::data_width-1:0] entry_data_q;
   logic                            new_write;
   logic                            stage_drained;
   logic                            capture;

   assign new_write = access.valid && access.write;

   // Data-phase write went straight to the array
   assign stage_drained = drain && !entry_vld_q;
   assign capture       = stage_vld_q && !stage_drained;

   // Address phase latch
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         stage_vld_q <= 1'b0;
      end else begin
         stage_vld_q <= new_write;
      end
   end

   always_ff @(posedge clk) begin
      if (new_write) begin
         stage_q <= access;
      end
   end

   // Held entry, a capture in a drain cycle reloads it
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         entry_vld_q <= 1'b0;
      end else if (capture) begin
         entry_vld_q <= 1'b1;
      end else if (drain) begin
         entry_vld_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         entry_q      <= stage_q;
         entry_data_q <= hwdata;  // Data phase word
      end
   end

   // Held entry first, else the write now in its data phase
   assign buf_pending = entry_vld_q || stage_vld_q;

   always_comb begin
      buf_entry       = entry_vld_q ? entry_q : stage_q;
      buf_entry.valid = buf_pending;
   end

   assign buf_wdata = entry_vld_q ? entry_data_q : hwdata;

endmodule

//--- rtl/sram_access_ctrl.sv
/*
 * SRAM access controller
 * Reads win the port, buffered writes take idle slots
 * Read data gets pending buffer bytes merged per lane
 */
`timescale 1ns/100ps

module sram_access_ctrl #(
   parameter int addr_width = 14
) (
   input  logic                              clk,
   input  logic                              rst_n,
   input  sram_pkg::access_t                 access,
   input  logic                              buf_pending,
   input  sram_pkg::access_t                 buf_entry,
   input  logic [sram_pkg::data_width-1:0]   buf_wdata,
   output logic                              drain,
   output sram_pkg::sram_port_t              sram,
   input  logic [sram_pkg::data_width-1:0]   sram_rdata,
   output logic [sram_pkg::data_width-1:0]   hrdata,
   output logic                              hready,
   output logic                              hresp
);

   logic                            rd_req;      // Read address phase this cycle
   logic                            same_word;
   logic                            rd_pend_q;   // Read data phase
   logic [sram_pkg::lane_count-1:0] fwd_mask_q;  // Lanes taken from the buffer

   assign rd_req    = access.valid && !access.write;
   assign drain     = buf_pending && !rd_req;  // Only in read-free cycles
   assign same_word = buf_entry.addr[addr_width-1:0] == access.addr[addr_width-1:0];

   // Port mux, read has priority
   always_comb begin
      sram.cs    = rd_req || drain;
      sram.wr    = drain;
      sram.addr  = rd_req ? access.addr : buf_entry.addr;
      sram.be    = buf_entry.be;  // Reads always fetch the whole word
      sram.wdata = buf_wdata;
   end

   // Forward mask set when the read hits the buffered word
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_pend_q  <= 1'b0;
         fwd_mask_q <= '0;
      end else begin
         rd_pend_q <= rd_req;
         if (rd_req && buf_pending && same_word) begin
            fwd_mask_q <= buf_entry.be;
         end else begin
            fwd_mask_q <= '0;
         end
      end
   end

   // Lane merge, buffered bytes are newer than the array
   always_comb begin
      hrdata = '0;
      if (rd_pend_q) begin
         for (int i = 0; i < sram_pkg::lane_count; i++) begin
            hrdata[8*i +: 8] = fwd_mask_q[i] ? buf_wdata[8*i +: 8] : sram_rdata[8*i +: 8];
         end
      end
   end

   // Zero wait states, never an error
   assign hready = 1'b1;
   assign hresp  = 1'b0;  // OKAY

endmodule

//--- rtl/sram_array.sv
/*
 * Single-port synchronous SRAM
 * Word wide with byte write enables, read data registered
 */
`timescale 1ns/100ps

module sram_array #(
   parameter int addr_width = 14
) (
   input  logic                            clk,
   input  sram_pkg::sram_port_t            sram,
   output logic [sram_pkg::data_width-1:0] rdata
);

   localparam int depth = 2 ** addr_width;

   logic [sram_pkg::data_width-1:0] mem [depth];
   logic [addr_width-1:0]           idx;

   assign idx = sram.addr[addr_width-1:0];  // Upper address bits ignored

   always_ff @(posedge clk) begin
      if (sram.cs) begin
         if (sram.wr) begin
            // Only enabled lanes change
            for (int i = 0; i < sram_pkg::lane_count; i++) begin
               if (sram.be[i]) begin
                  mem[idx][8*i +: 8] <= sram.wdata[8*i +: 8];
               end
            end
         end else begin
            rdata <= mem[idx];  // Valid the cycle after cs
         end
      end
   end

endmodule

//--- rtl/sram_pkg.sv
/*
 * SRAM side types
 * Data and lane widths, the word access request and the
 * port bundle that drives the memory array
 */
package sram_pkg;

   localparam int data_width = 32;
   localparam int lane_count = data_width / 8;  // One enable per byte

   // One word-level access, address in words
   typedef struct packed {
      logic                  valid;
      logic                  write;
      logic [31:0]           addr;  // Low addr_width bits used
      logic [lane_count-1:0] be;
   } access_t;

   // Array port, sampled at the rising edge
   typedef struct packed {
      logic                  cs;
      logic                  wr;     // Write when set, else read
      logic [31:0]           addr;
      logic [lane_count-1:0] be;
      logic [data_width-1:0] wdata;
   } sram_port_t;

endpackage

//--- testbench/ahb_sram_tb.sv
/*
 * Testbench for the AHB-Lite SRAM bridge
 * Byte-wide reference memory, pipelined AHB stimulus and a
 * negedge compare of hrdata, hready and hresp
 */
`timescale 1ns/100ps

module ahb_sram_tb;

   localparam int addr_width  = 8;
   localparam int bw          = addr_width + 2;  // Byte address bits
   localparam int xfer_count  = 303;             // Transfers and idle cycles issued
   localparam int cycle_limit = 4 * xfer_count + 50;

   logic              clk = 1'b0;
   logic              rst_n;
   ahb_pkg::ahb_req_t ahb_req;
   logic [31:0]       hwdata;
   logic [31:0]       hrdata;
   logic              hready;
   logic              hresp;

   logic [7:0]  ref_bytes [2**bw];  // Reference memory
   logic        wr_pend;            // Write owed a data phase
   logic [31:0] wr_addr;
   logic [2:0]  wr_size;
   logic [31:0] wr_data;
   logic        rd_phase;           // Read in the current address phase
   logic [31:0] rd_addr;
   logic        chk_valid = 1'b0;   // Read data due this cycle
   logic [31:0] chk_addr;
   logic [31:0] exp_data;
   int          data_errors = 0;
   int          status_errors = 0;
   int          base_errors = 0;
   int          passed = 0;
   int          failed = 0;
   int          cycles = 0;

   ahb_sram_top #(.addr_width(addr_width)) dut_i (.*);

   always #20 clk = ~clk;

   // Byte address a lives on lane a mod 4
   task automatic store_ref(input logic [31:0] addr, input logic [2:0] size,
                            input logic [31:0] data);
      int nbytes;
      int base;
      nbytes = (size == 3'd0) ? 1 : (size == 3'd1) ? 2 : 4;  // Wider codes act as word
      base   = int'(addr[bw-1:0]) & ~(nbytes - 1);
      for (int j = base; j < base + nbytes; j++) begin
         ref_bytes[bw'(j)] = data[8*(j%4) +: 8];
      end
   endtask

   // Whole word back, whatever the read size
   function automatic logic [31:0] expected_read(input logic [31:0] addr);
      logic [31:0] word;
      for (int i = 0; i < 4; i++) begin
         word[8*i +: 8] = ref_bytes[{addr[bw-1:2], 2'(i)}];
      end
      return word;
   endfunction

   // kind 0 NONSEQ, 1 IDLE, 2 BUSY, 3 hsel low, 4 hreadym low, 5 SEQ
   task automatic xfer(input int kind, input logic write, input logic [31:0] addr,
                       input logic [2:0] size, input logic [31:0] data);
      ahb_pkg::ahb_req_t req;
      logic              qualified;
      @(posedge clk);
      req            = '0;
      req.hsel       = (kind != 3);
      req.hreadym    = (kind != 4);
      req.htrans     = (kind == 1) ? ahb_pkg::IDLE : (kind == 2) ? ahb_pkg::BUSY :
                       (kind == 5) ? ahb_pkg::SEQ : ahb_pkg::NONSEQ;
      req.hwrite     = write;
      req.haddr.flat = addr;
      req.hsize      = ahb_pkg::hsize_t'(size);
      ahb_req <= req;
      hwdata  <= wr_pend ? wr_data : 32'hdead_beef;  // Data phase of the write before
      if (wr_pend) begin
         store_ref(wr_addr, wr_size, wr_data);
      end
      qualified = (kind == 0) || (kind == 5);
      wr_pend   = qualified && write;
      wr_addr   = addr;
      wr_size   = size;
      wr_data   = data;
      rd_phase <= qualified && !write;
      rd_addr  <= addr;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) xfer(1, 1'b0, '0, 3'd2, '0);
   endtask

   task automatic report_test(input int num, input string name, input int errs);
      if (errs == 0) begin
         $display("Test %0d %s: ok", num, name);
         passed++;
      end else begin
         $display("Test %0d %s: %0d errors", num, name, errs);
         failed++;
      end
      base_errors = data_errors;
   endtask

   // Read pipeline and watchdog
   always @(posedge clk) begin
      chk_valid <= rd_phase;
      chk_addr  <= rd_addr;
      cycles    <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("Timeout, stimulus still running after %0d cycles", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   // Outputs settle well before the falling edge
   always @(negedge clk) begin
      if (rst_n) begin
         assert (hready === 1'b1) else begin
            $display("FAIL hready expected %h got %h", 1'b1, hready);
            status_errors++;
         end
         assert (hresp === 1'b0) else begin
            $display("FAIL hresp expected %h got %h", 1'b0, hresp);
            status_errors++;
         end
      end
      if (chk_valid) begin
         exp_data = expected_read(chk_addr);
         assert (hrdata === exp_data) else begin
            $display("FAIL hrdata at %h expected %h got %h", chk_addr, exp_data, hrdata);
            data_errors++;
         end
      end
   end

   initial begin
      logic [31:0] addr;
      logic [2:0]  size;
      rst_n    = 1'b0;
      ahb_req  = '0;
      hwdata   = '0;
      wr_pend  = 1'b0;
      rd_phase = 1'b0;
      rd_addr  = '0;
      void'($urandom(11));
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < 16; i++) begin
         addr = 32'(i) << 6;  // Spread over the array
         xfer(0, 1'b1, addr, 3'd2, {~addr[15:0], addr[15:0]});
      end
      idle_cycles(2);
      for (int i = 0; i < 16; i++) begin
         xfer(0, 1'b0, 32'(i) << 6, 3'd2, '0);
      end
      idle_cycles(2);
      report_test(2, "word write and readback", data_errors - base_errors);
      xfer(0, 1'b1, 32'h50, 3'd0, 32'h0000_0011);  // Lane 0
      xfer(0, 1'b1, 32'h51, 3'd0, 32'h0000_2200);  // Lane 1
      xfer(0, 1'b1, 32'h52, 3'd1, 32'h4433_0000);  // Upper half
      idle_cycles(2);
      xfer(0, 1'b0, 32'h50, 3'd2, '0);
      xfer(0, 1'b0, 32'h53, 3'd0, '0);
      xfer(0, 1'b0, 32'h52, 3'd1, '0);
      xfer(0, 1'b0, 32'h50, 3'd1, '0);
      idle_cycles(2);
      report_test(3, "byte and halfword merge", data_errors - base_errors);
      xfer(0, 1'b1, 32'h60, 3'd2, 32'h1357_9bdf);
      idle_cycles(2);
      xfer(0, 1'b1, 32'h62, 3'd0, 32'h00ee_0000);
      xfer(0, 1'b0, 32'h60, 3'd2, '0);  // Buffered byte over array word
      xfer(0, 1'b1, 32'h64, 3'd2, 32'h2468_ace0);
      xfer(0, 1'b0, 32'h60, 3'd2, '0);  // Other word, old contents
      xfer(0, 1'b1, 32'h68, 3'd2, 32'h0f1e_2d3c);
      xfer(0, 1'b0, 32'h68, 3'd2, '0);
      idle_cycles(2);
      report_test(4, "read after write forwarding", data_errors - base_errors);
      for (int k = 1; k <= 4; k++) begin
         xfer(k, 1'b1, 32'(k) << 6, 3'd2, 32'hbad0_0000 | 32'(k));  // Must be ignored
      end
      idle_cycles(1);
      for (int k = 1; k <= 4; k++) begin
         xfer(0, 1'b0, 32'(k) << 6, 3'd2, '0);
      end
      idle_cycles(2);
      report_test(5, "unqualified transfers", data_errors - base_errors);
      for (int i = 0; i < 32; i++) begin
         xfer(0, 1'b1, 32'(i) * 4, 3'd2, $urandom);
      end
      for (int i = 0; i < 200; i++) begin
         size = 3'($urandom % 3);
         addr = ($urandom % 128) & ~((32'd1 << size) - 1);  // Aligned to size
         xfer(($urandom % 2) ? 5 : 0, 1'($urandom % 2), addr, size, $urandom);
      end
      idle_cycles(2);
      report_test(6, "random back to back", data_errors - base_errors);
      report_test(1, "hready and hresp", status_errors);
      $display("Tests passed %0d, failed %0d", passed, failed);
      if (failed == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule
